// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_adc_frontend
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/adc_convert_seq.sv
`timescale 1ns/10ps
`default_nettype none

module adc_convert_seq #(
	parameter int MIN_T_CYCLE = adc_pkg::adc_min_t_cycle_def  // min cycle in clk_in cycles
) (
	input  wire  clk_in,
	input  wire  reset_in,
	input  wire  cstart_in,                    // one-cycle start of continuous mode
	input  wire  busy_in,                      // converter busy
	output logic convst_out                    // active low convert start
);

	import adc_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// state and cycle counter
	////////////////////////////////////////////////////////////////////////////

	cv_state_t cv_state;                       // current state
	cv_state_t cv_next;                        // next state
	logic [adc_cnt_w-1:0] cv_cnt;              // cycles spent in current state
	logic cv_min_done;                         // minimum cycle time elapsed

	assign cv_min_done = (cv_cnt >= adc_cnt_w'(MIN_T_CYCLE));

	always_comb begin
		cv_next = cv_state;                    // hold by default
		case (cv_state)
			cv_idle: begin
				if (cstart_in)
					cv_next = cv_convst;       // start only from idle
			end
			cv_convst: begin
				cv_next = cv_conv;             // single cycle pulse
			end
			cv_conv: begin
				if (cv_min_done && !busy_in)
					cv_next = cv_convst;       // next conversion
			end
			default: begin
				cv_next = cv_idle;
			end
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			cv_state <= cv_idle;
			cv_cnt   <= '0;
		end else begin
			cv_state <= cv_next;
			if (cv_state != cv_next)
				cv_cnt <= '0;                  // restart on every transition
			else if (cv_cnt != '1)
				cv_cnt <= cv_cnt + 1'b1;       // saturate, no wrap
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// convst pulse, one cycle behind the convst state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in)
			convst_out <= 1'b1;                // idle high
		else
			convst_out <= ~(cv_state == cv_convst);
	end

endmodule

`default_nettype wire

// File: hw/adc_frontend_top.sv
`timescale 1ns/10ps
`default_nettype none

module adc_frontend_top #(
	parameter int W_OUT       = adc_pkg::adc_w_out_def,
	parameter int N_CHAN      = adc_pkg::adc_n_chan_def,
	parameter int MIN_T_CYCLE = adc_pkg::adc_min_t_cycle_def
) (
	input  wire                            clk_in,
	input  wire                            reset_in,
	input  wire                            cstart_in,        // starts continuous mode
	input  wire  [adc_pkg::adc_os_w-1:0]   os_in,            // oversampling code
	input  wire                            busy_in,          // from converter
	input  wire                            data_a_in,        // serial line a
	input  wire                            data_b_in,        // serial line b
	input  wire  [$clog2(N_CHAN)-1:0]      ch_sel_in,        // bank read address
	output wire  [adc_pkg::adc_os_w-1:0]   os_out,           // to converter
	output wire                            convst_out,       // active low
	output wire                            reset_out,        // converter reset
	output wire                            sclk_out,
	output wire                            n_cs_out,
	output wire  [N_CHAN-1:0]              data_valid_out,   // one-hot per pair
	output wire  signed [W_OUT-1:0]        data_a_out,
	output wire  signed [W_OUT-1:0]        data_b_out,
	output wire                            frame_valid_out,
	output wire  signed [W_OUT-1:0]        ch_data_out
);

	import adc_pkg::*;

	localparam int IDX_W = (N_CHAN / 2 > 1) ? $clog2(N_CHAN / 2) : 1;

	wire                     word_valid;       // reader to bank
	wire [IDX_W-1:0]         word_index;
	wire signed [W_OUT-1:0]  word_a;
	wire signed [W_OUT-1:0]  word_b;

	assign os_out    = os_in;                  // straight to the pins
	assign reset_out = reset_in;

	////////////////////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////////////////////

	adc_convert_seq #(
		.MIN_T_CYCLE (MIN_T_CYCLE)
	) u_convert_seq (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.cstart_in  (cstart_in),
		.busy_in    (busy_in),
		.convst_out (convst_out)
	);

	// reads the previous result while the next conversion runs
	adc_serial_reader #(
		.W_OUT  (W_OUT),
		.N_CHAN (N_CHAN),
		.IDX_W  (IDX_W)
	) u_serial_reader (
		.clk_in     (clk_in),
		.reset_in   (reset_in),
		.busy_in    (busy_in),
		.data_a_in  (data_a_in),
		.data_b_in  (data_b_in),
		.n_cs_out   (n_cs_out),
		.sclk_out   (sclk_out),
		.word_valid (word_valid),
		.word_index (word_index),
		.word_a     (word_a),
		.word_b     (word_b)
	);

	adc_sample_bank #(
		.W_OUT  (W_OUT),
		.N_CHAN (N_CHAN),
		.IDX_W  (IDX_W)
	) u_sample_bank (
		.clk_in          (clk_in),
		.reset_in        (reset_in),
		.word_valid      (word_valid),
		.word_index      (word_index),
		.word_a          (word_a),
		.word_b          (word_b),
		.ch_sel_in       (ch_sel_in),
		.data_valid_out  (data_valid_out),
		.data_a_out      (data_a_out),
		.data_b_out      (data_b_out),
		.frame_valid_out (frame_valid_out),
		.ch_data_out     (ch_data_out)
	);

endmodule

`default_nettype wire

// File: hw/adc_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// shared constants and state encodings for the converter front end
////////////////////////////////////////////////////////////////////////////

package adc_pkg;

	// default geometry of the converter
	localparam int adc_w_out_def       = 18;   // sample width
	localparam int adc_n_chan_def      = 8;    // channels, read as pairs
	localparam int adc_os_w            = 3;    // oversampling code width

	// counters of both state machines
	localparam int adc_cnt_w           = 8;    // holds read length and min cycle
	localparam int adc_min_t_cycle_def = 160;  // above 2*72+4 read cycles

	// conversion sequencer states
	typedef enum logic [1:0] {
		cv_idle   = 2'd0,                      // wait for start pulse
		cv_convst = 2'd1,                      // convst low for one cycle
		cv_conv   = 2'd2                       // pace the conversion cycle
	} cv_state_t;

	// serial reader states
	typedef enum logic [1:0] {
		rd_idle = 2'd0,                        // wait for busy high
		rd_read = 2'd1,                        // clock out both lines
		rd_wait = 2'd2                         // wait for busy low
	} rd_state_t;

endpackage

`default_nettype wire

// File: hw/adc_sample_bank.sv
`timescale 1ns/10ps
`default_nettype none

module adc_sample_bank #(
	parameter int W_OUT  = adc_pkg::adc_w_out_def,
	parameter int N_CHAN = adc_pkg::adc_n_chan_def,
	parameter int IDX_W  = (N_CHAN / 2 > 1) ? $clog2(N_CHAN / 2) : 1,
	parameter int SEL_W  = $clog2(N_CHAN)
) (
	input  wire                      clk_in,
	input  wire                      reset_in,
	input  wire                      word_valid,       // word strobe from reader
	input  wire  [IDX_W-1:0]         word_index,       // pair number
	input  wire  signed [W_OUT-1:0]  word_a,           // low half channel
	input  wire  signed [W_OUT-1:0]  word_b,           // high half channel
	input  wire  [SEL_W-1:0]         ch_sel_in,        // read port address
	output logic [N_CHAN-1:0]        data_valid_out,   // one-hot per pair
	output logic signed [W_OUT-1:0]  data_a_out,
	output logic signed [W_OUT-1:0]  data_b_out,
	output logic                     frame_valid_out,  // with the last pair
	output logic signed [W_OUT-1:0]  ch_data_out       // selected channel
);

	import adc_pkg::*;

	localparam int HALF = N_CHAN / 2;          // pairs per frame

	logic signed [W_OUT-1:0] sample_q [N_CHAN];  // latest word of each channel

	////////////////////////////////////////////////////////////////////////////
	// channel registers and strobes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			for (int c = 0; c < N_CHAN; c++)
				sample_q[c] <= '0;
			data_valid_out  <= '0;
			frame_valid_out <= 1'b0;
		end else begin
			data_valid_out  <= '0;             // strobes last one cycle
			frame_valid_out <= word_valid && (word_index == IDX_W'(HALF - 1));
			for (int p = 0; p < HALF; p++) begin
				if (word_valid && (word_index == IDX_W'(p))) begin
					sample_q[p]            <= word_a;
					sample_q[p + HALF]     <= word_b;
					data_valid_out[p]      <= 1'b1;
					data_valid_out[p + HALF] <= 1'b1;
				end
			end
		end
	end

	// pair outputs follow each word
	always_ff @(posedge clk_in) begin
		if (word_valid) begin
			data_a_out <= word_a;
			data_b_out <= word_b;
		end
	end

	assign ch_data_out = sample_q[ch_sel_in];  // async read port

endmodule

`default_nettype wire

// File: hw/adc_serial_reader.sv
`timescale 1ns/10ps
`default_nettype none

module adc_serial_reader #(
	parameter int W_OUT  = adc_pkg::adc_w_out_def,   // bits per word
	parameter int N_CHAN = adc_pkg::adc_n_chan_def,  // channels, two per word slot
	parameter int IDX_W  = (N_CHAN / 2 > 1) ? $clog2(N_CHAN / 2) : 1
) (
	input  wire                      clk_in,
	input  wire                      reset_in,
	input  wire                      busy_in,      // converter busy
	input  wire                      data_a_in,    // serial line a
	input  wire                      data_b_in,    // serial line b
	output logic                     n_cs_out,     // chip select, active low
	output logic                     sclk_out,     // serial clock, idles high
	output logic                     word_valid,   // one-cycle word strobe
	output logic [IDX_W-1:0]         word_index,   // pair number of the word
	output logic signed [W_OUT-1:0]  word_a,       // line a shift register
	output logic signed [W_OUT-1:0]  word_b        // line b shift register
);

	import adc_pkg::*;

	localparam int RD_LENGTH = W_OUT * (N_CHAN / 2);  // bits per line per read
	localparam int RD_HALF   = 2 * RD_LENGTH;         // half-bit cycles per read
	localparam int BIT_W     = $clog2(W_OUT);

	////////////////////////////////////////////////////////////////////////////
	// read state machine
	////////////////////////////////////////////////////////////////////////////

	rd_state_t rd_state;
	rd_state_t rd_next;
	logic [adc_cnt_w-1:0] rd_cnt;              // half-bit cycle count
	logic rd_active;                           // inside the chip select window
	logic bit_take;                            // rising sclk phase, sample now
	logic [BIT_W-1:0] bit_cnt;                 // bit position inside word

	assign rd_active = (rd_state == rd_read) && (rd_cnt < adc_cnt_w'(RD_HALF));
	assign bit_take  = rd_active && rd_cnt[0]; // odd half is the rising one

	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			rd_idle: begin
				if (busy_in)
					rd_next = rd_read;         // new result available
			end
			rd_read: begin
				if (rd_cnt == adc_cnt_w'(RD_HALF))
					rd_next = rd_wait;
			end
			rd_wait: begin
				if (!busy_in)
					rd_next = rd_idle;         // one read per busy pulse
			end
			default: begin
				rd_next = rd_idle;
			end
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			rd_state <= rd_idle;
			rd_cnt   <= '0;
		end else begin
			rd_state <= rd_next;
			if (rd_state != rd_next)
				rd_cnt <= '0;
			else if (rd_cnt != '1)
				rd_cnt <= rd_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// serial pins, registered
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			n_cs_out <= 1'b1;
			sclk_out <= 1'b1;
		end else begin
			n_cs_out <= ~rd_active;
			sclk_out <= rd_active ? rd_cnt[0] : 1'b1;  // low then high per bit
		end
	end

	// msb first, both lines together
	always_ff @(posedge clk_in) begin
		if (bit_take) begin
			word_a <= {word_a[W_OUT-2:0], data_a_in};
			word_b <= {word_b[W_OUT-2:0], data_b_in};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// word boundaries
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			bit_cnt    <= '0;
			word_valid <= 1'b0;
			word_index <= '0;
		end else begin
			word_valid <= bit_take && (bit_cnt == BIT_W'(W_OUT - 1));  // last bit in
			if (rd_state == rd_idle) begin
				bit_cnt    <= '0;              // fresh frame
				word_index <= '0;
			end else begin
				if (bit_take)
					bit_cnt <= (bit_cnt == BIT_W'(W_OUT - 1)) ? '0 : bit_cnt + 1'b1;
				if (word_valid)
					word_index <= word_index + 1'b1;  // after the strobe cycle
			end
		end
	end

endmodule

`default_nettype wire

// File: tb.f
hw/adc_pkg.sv
hw/adc_convert_seq.sv
hw/adc_serial_reader.sv
hw/adc_sample_bank.sv
hw/adc_frontend_top.sv
verif/ad7608_model.sv
verif/tb_adc_frontend.sv

// File: verif/ad7608_model.sv
`timescale 1ns/10ps
`default_nettype none

module ad7608_model (
	input  wire  clk_in,
	input  wire  convst_n,                     // convert start, active low
	input  wire  sclk,                         // serial clock from the reader
	output logic busy,                         // conversion in progress
	output logic data_a,                       // channels 0 to 3
	output logic data_b                        // channels 4 to 7
);

	localparam int W          = 18;            // bits per sample
	localparam int PAIRS      = 4;             // words per line per frame
	localparam int FRAME_BITS = W * PAIRS;     // bits per line per frame

	int frame_cnt = 0;                         // conversions started so far
	int cur_frame = 0;                         // frame shifted out on the lines

	// known test pattern, frame f and channel c
	function automatic logic [17:0] pattern(input int f, input int c);
		return 18'((f * 8 + c) * 9337);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// conversion, busy after each convst
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int len;
		busy = 1'b0;
		forever begin
			@(negedge convst_n);
			cur_frame = frame_cnt;             // latch frame number
			frame_cnt++;
			len = $urandom_range(60, 20);      // busy length in clk_in cycles
			@(posedge clk_in);
			#1 busy = 1'b1;
			repeat (len) @(posedge clk_in);
			#1 busy = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// serial lines, new bit on each falling sclk
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int bit_pos;
		logic [17:0] wa;
		logic [17:0] wb;
		bit_pos = 0;
		data_a  = 1'b0;
		data_b  = 1'b0;
		forever begin
			@(negedge sclk);
			wa = pattern(cur_frame, bit_pos / W);          // word on line a
			wb = pattern(cur_frame, bit_pos / W + PAIRS);  // word on line b
			data_a = 1'(wa >> (W - 1 - bit_pos % W));      // msb first
			data_b = 1'(wb >> (W - 1 - bit_pos % W));
			bit_pos = (bit_pos == FRAME_BITS - 1) ? 0 : bit_pos + 1;  // wrap per frame
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_adc_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_adc_frontend;

	localparam int MIN_CYCLE      = 160;                   // default minimum cycle
	localparam int N_PAIRS        = 4;
	localparam int BITS_PER_READ  = 72;                    // sclk rises per window
	localparam int N_FRAMES       = 6;
	localparam int TIMEOUT_CYCLES = N_FRAMES * 250 + 500;
	localparam bit [31:0] SEED    = 32'h9212c0c3;

	localparam logic [2:0] T_RESET = 3'd0;                 // test ids
	localparam logic [2:0] T_PACE  = 3'd1;
	localparam logic [2:0] T_FRAME = 3'd2;
	localparam logic [2:0] T_VALUE = 3'd3;
	localparam logic [2:0] T_READ  = 3'd4;

	logic clk_in = 1'b0;
	logic reset_in, cstart_in, busy_in, data_a_in, data_b_in;
	logic [2:0] os_in, os_out, ch_sel_in;
	logic convst_out, reset_out, sclk_out, n_cs_out, frame_valid_out;
	logic [7:0] data_valid_out;
	logic signed [17:0] data_a_out, data_b_out, ch_data_out;

	int errs [5];                                          // errors per test
	int checks, cycle_cnt, cyc;
	bit go, read_pending;
	bit convst_prev = 1'b1, ncs_prev = 1'b1, sclk_prev = 1'b1, busy_prev = 1'b0;
	int cstart_cyc, last_conv_cyc, conv_cnt, busy_fall_cyc, busy_rises;
	int windows, sclk_rises, pair_exp, frames_done, read_frame;

	always #4 clk_in = ~clk_in;                            // 8 ns period

	adc_frontend_top u_adc_frontend_top (
		.clk_in (clk_in), .reset_in (reset_in), .cstart_in (cstart_in), .os_in (os_in),
		.busy_in (busy_in), .data_a_in (data_a_in), .data_b_in (data_b_in),
		.ch_sel_in (ch_sel_in), .os_out (os_out), .convst_out (convst_out),
		.reset_out (reset_out), .sclk_out (sclk_out), .n_cs_out (n_cs_out),
		.data_valid_out (data_valid_out), .data_a_out (data_a_out),
		.data_b_out (data_b_out), .frame_valid_out (frame_valid_out),
		.ch_data_out (ch_data_out)
	);

	ad7608_model u_model (
		.clk_in (clk_in), .convst_n (convst_out), .sclk (sclk_out),
		.busy (busy_in), .data_a (data_a_in), .data_b (data_b_in)
	);

	////////////////////////////////////////////////////////////////////////////
	// reference and reporting
	////////////////////////////////////////////////////////////////////////////

	// ((f*8 + c) * 9337) mod 2^18, read as signed
	function automatic logic signed [17:0] ref_sample(input int f, input int c);
		return 18'((f * 8 + c) * 9337);
	endfunction

	function automatic logic [7:0] pair_mask(input int i);
		return 8'(1 << i) | 8'(1 << (i + N_PAIRS));        // pair i and its partner
	endfunction

	task automatic check(input logic [2:0] t, input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("error %0t ns: %s", $time, msg);
			errs[t]++;
		end
	endtask

	task automatic report_test(input logic [2:0] t);
		string label;
		case (t)
			T_RESET: label = "reset state";
			T_PACE:  label = "conversion pacing";
			T_FRAME: label = "serial framing";
			T_VALUE: label = "sample values";
			default: label = "frame end and read port";
		endcase
		if (errs[t] == 0)
			$display("test %s: pass", label);
		else
			$display("test %s: FAIL, %0d errors", label, errs[t]);
	endtask

	always @(posedge clk_in) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: the frames did not arrive within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// comparing process, samples at mid cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk_in) begin
		cyc++;
		if (!go) begin                                     // before the start pulse
			check(T_RESET, reset_out == reset_in, "reset_out does not follow reset_in");
			if (!reset_in) begin
				check(T_RESET, convst_out && n_cs_out && sclk_out, $sformatf(
					"pins not idle, convst %b n_cs %b sclk %b", convst_out, n_cs_out, sclk_out));
				check(T_RESET, data_valid_out == '0 && !frame_valid_out, "strobe before start");
				check(T_RESET, ch_data_out == '0, $sformatf("channel %0d reads %0d, expected 0",
					ch_sel_in, ch_data_out));
				check(T_RESET, os_out == os_in, $sformatf("os_out %0d, os_in %0d", os_out, os_in));
			end
			if (cstart_in) begin
				go         = 1'b1;
				cstart_cyc = cyc;
			end
		end
		// convst pacing
		if (!convst_out) begin
			check(T_PACE, convst_prev, "convst held low for more than one cycle");
			if (convst_prev) begin
				if (conv_cnt == 0)
					check(T_PACE, cyc - cstart_cyc == 2, $sformatf(
						"first convst %0d cycles after start taken, expected 1",
						cyc - cstart_cyc - 1));
				else begin
					check(T_PACE, cyc - last_conv_cyc >= MIN_CYCLE + 2, $sformatf(
						"convst period %0d, expected at least %0d", cyc - last_conv_cyc,
						MIN_CYCLE + 2));
					check(T_PACE, !busy_in && cyc - busy_fall_cyc >= 2, $sformatf(
						"convst %0d cycles after busy fell", cyc - busy_fall_cyc));
				end
				last_conv_cyc = cyc;
				conv_cnt++;
			end
		end
		// busy pulses against chip select windows
		if (busy_in && !busy_prev)
			busy_rises++;
		if (!busy_in && busy_prev)
			busy_fall_cyc = cyc;
		if (!n_cs_out && ncs_prev) begin
			windows++;
			sclk_rises = 0;
			check(T_FRAME, windows == busy_rises, $sformatf("window %0d during busy pulse %0d",
				windows, busy_rises));
		end
		if (n_cs_out)
			check(T_FRAME, sclk_out, "sclk went low outside the chip select window");
		else if (sclk_out && !sclk_prev)
			sclk_rises++;
		if (n_cs_out && !ncs_prev)
			check(T_FRAME, sclk_rises == BITS_PER_READ, $sformatf("%0d sclk rises, expected %0d",
				sclk_rises, BITS_PER_READ));
		// read port, one cycle after the frame strobe
		if (read_pending) begin
			check(T_READ, ch_data_out == ref_sample(read_frame, int'(ch_sel_in)), $sformatf(
				"channel %0d reads %0d, expected %0d", ch_sel_in, ch_data_out,
				ref_sample(read_frame, int'(ch_sel_in))));
			read_pending = 1'b0;
		end
		// pair strobes and values
		if (data_valid_out != '0) begin
			check(T_VALUE, data_valid_out == pair_mask(pair_exp), $sformatf(
				"valid %b, expected %b", data_valid_out, pair_mask(pair_exp)));
			check(T_VALUE, data_a_out == ref_sample(frames_done, pair_exp), $sformatf(
				"frame %0d pair %0d a %0d, expected %0d", frames_done, pair_exp, data_a_out,
				ref_sample(frames_done, pair_exp)));
			check(T_VALUE, data_b_out == ref_sample(frames_done, pair_exp + N_PAIRS), $sformatf(
				"frame %0d pair %0d b %0d, expected %0d", frames_done, pair_exp, data_b_out,
				ref_sample(frames_done, pair_exp + N_PAIRS)));
			check(T_READ, frame_valid_out == (pair_exp == N_PAIRS - 1), $sformatf(
				"frame strobe %b on pair %0d", frame_valid_out, pair_exp));
			if (pair_exp == N_PAIRS - 1) begin
				pair_exp     = 0;
				read_frame   = frames_done;
				read_pending = 1'b1;
				frames_done++;
			end else
				pair_exp++;
		end else
			check(T_READ, !frame_valid_out, "frame strobe without a pair strobe");
		convst_prev = convst_out;
		ncs_prev    = n_cs_out;
		sclk_prev   = sclk_out;
		busy_prev   = busy_in;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus, 1 ns after the rising edge
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int total;
		void'($urandom(SEED));
		reset_in  = 1'b1;
		cstart_in = 1'b0;
		os_in     = '0;
		ch_sel_in = '0;
		repeat (5) @(posedge clk_in);
		#1 reset_in = 1'b0;
		for (int c = 0; c < 8; c++) begin                  // sweep the read port
			@(posedge clk_in);
			#1;
			ch_sel_in = 3'(c);
			os_in     = 3'($urandom_range(7, 0));
		end
		@(posedge clk_in);
		#1 cstart_in = 1'b1;
		@(posedge clk_in);
		#1 cstart_in = 1'b0;
		report_test(T_RESET);                              // idle phase over
		while (frames_done < N_FRAMES) begin
			@(posedge clk_in);
			#1;
			ch_sel_in = 3'($urandom_range(7, 0));
			os_in     = 3'($urandom_range(7, 0));
		end
		repeat (4) @(posedge clk_in);
		check(T_PACE, conv_cnt == N_FRAMES, $sformatf("%0d conversions, expected %0d",
			conv_cnt, N_FRAMES));
		check(T_FRAME, windows == busy_rises && windows == N_FRAMES, $sformatf(
			"%0d windows for %0d busy pulses", windows, busy_rises));
		total = errs[T_RESET];
		for (int t = 1; t < 5; t++) begin
			report_test(3'(t));
			total += errs[3'(t)];
		end
		$display("%0d checks, %0d errors", checks, total);
		if (total == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
